/* hdl/bsmac_pkg.sv */
package bsmac_pkg;

    // Array geometry
    localparam int NUM_ROWS = 16;
    localparam int NUM_COLS = 4;

    // Activations are two's complement
    localparam int ACT_BITS = 8;

    // Magnitude bits config, legal range 1 to 7
    localparam int MAG_BITS_W = 3;

    // ADC range shift config, 0 to 3
    localparam int SHIFT_W = 2;

    // Signed ADC output code
    localparam int ADC_BITS = 5;

    // Signed shift-accumulator
    localparam int ACC_BITS = 16;

    // Scaled result, room for the largest range shift
    localparam int OUT_BITS = ACC_BITS + 3;

    // Longest pipeline is max magnitude bits plus ADC and accumulate stages
    localparam int TRACK_DEPTH = (2 ** MAG_BITS_W - 1) + 2;

    // Weight row address
    localparam int ROW_ADDR_W = $clog2(NUM_ROWS);

endpackage

/* hdl/act_serializer.sv */
module act_serializer
    import bsmac_pkg::*;
(
    input  logic                               clk,
    input  logic                               nrst,
    input  logic [MAG_BITS_W-1:0]              cfg_mag_bits_i,
    input  logic [NUM_ROWS-1:0][ACT_BITS-1:0]  act_i,
    input  logic                               load_i,
    output logic [NUM_ROWS-1:0]                trit_p_o,
    output logic [NUM_ROWS-1:0]                trit_n_o
);

    // Magnitudes never exceed 7 bits after saturation
    logic [NUM_ROWS-1:0][ACT_BITS-2:0] mag_p_q;
    logic [NUM_ROWS-1:0][ACT_BITS-2:0] mag_n_q;
    logic [NUM_ROWS-1:0][ACT_BITS-2:0] mag_p_d;
    logic [NUM_ROWS-1:0][ACT_BITS-2:0] mag_n_d;
    logic [ACT_BITS-1:0]               sat_limit;
    logic [ACT_BITS-1:0]               abs_val [NUM_ROWS];
    logic [ACT_BITS-1:0]               sat_mag [NUM_ROWS];

    always_comb begin
        // Largest magnitude that N bits can carry
        sat_limit = (ACT_BITS'(1) << cfg_mag_bits_i) - ACT_BITS'(1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            // -128 comes out as 8'h80 here and is saturated below
            abs_val[r] = act_i[r][ACT_BITS-1] ? -act_i[r] : act_i[r];
            sat_mag[r] = (abs_val[r] > sat_limit) ? sat_limit : abs_val[r];

            // Sign picks which side carries the magnitude
            if (act_i[r][ACT_BITS-1]) begin
                mag_p_d[r] = '0;
                mag_n_d[r] = sat_mag[r][ACT_BITS-2:0];
            end else begin
                mag_p_d[r] = sat_mag[r][ACT_BITS-2:0];
                mag_n_d[r] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            mag_p_q <= '0;
            mag_n_q <= '0;
        end else if (load_i) begin
            mag_p_q <= mag_p_d;
            mag_n_q <= mag_n_d;
        end else begin
            // Next bit-plane, LSB first
            for (int r = 0; r < NUM_ROWS; r++) begin
                mag_p_q[r] <= mag_p_q[r] >> 1;
                mag_n_q[r] <= mag_n_q[r] >> 1;
            end
        end
    end

    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            trit_p_o[r] = mag_p_q[r][0];
            trit_n_o[r] = mag_n_q[r][0];
        end
    end

    // A row is either positive or negative, so a trit is never both
    trit_exclusive_a: assert property (
        @(posedge clk) disable iff (!nrst)
        (trit_p_o & trit_n_o) == '0
    );

endmodule

/* hdl/weight_store.sv */
module weight_store
    import bsmac_pkg::*;
(
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               wgt_we_i,
    input  logic [ROW_ADDR_W-1:0]              wgt_addr_i,
    input  logic [NUM_COLS-1:0]                wgt_data_i,
    output logic [NUM_ROWS-1:0][NUM_COLS-1:0]  weights_o
);

    // One binary weight per cell
    logic [NUM_ROWS-1:0][NUM_COLS-1:0] cells_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            cells_q <= '0;
        end else if (wgt_we_i) begin
            cells_q[wgt_addr_i] <= wgt_data_i;
        end
    end

    // Every cell drives the array at once
    assign weights_o = cells_q;

    // Address must be known and name a real row
    wgt_addr_range_a: assert property (
        @(posedge clk) disable iff (!nrst)
        wgt_we_i |-> (!$isunknown(wgt_addr_i) && int'(wgt_addr_i) < NUM_ROWS)
    );

endmodule

/* hdl/column_adc.sv */
module column_adc
    import bsmac_pkg::*;
(
    input  logic                               clk,
    input  logic                               nrst,
    input  logic [SHIFT_W-1:0]                 cfg_range_shift_i,
    input  logic [NUM_ROWS-1:0]                trit_p_i,
    input  logic [NUM_ROWS-1:0]                trit_n_i,
    input  logic [NUM_ROWS-1:0][NUM_COLS-1:0]  weights_i,
    output logic [NUM_COLS-1:0][ADC_BITS-1:0]  adc_code_o
);

    // Sum spans -NUM_ROWS..NUM_ROWS
    logic signed [ROW_ADDR_W+1:0] col_sum     [NUM_COLS];
    logic signed [ROW_ADDR_W+1:0] col_shifted [NUM_COLS];
    logic signed [ADC_BITS-1:0]   code_d      [NUM_COLS];
    logic signed [ADC_BITS-1:0]   code_q      [NUM_COLS];
    logic        [ROW_ADDR_W+1:0] active_rows;

    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            col_sum[c] = '0;
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (weights_i[r][c]) begin
                    col_sum[c] = col_sum[c] + $signed({1'b0, trit_p_i[r]})
                                            - $signed({1'b0, trit_n_i[r]});
                end
            end

            // Coarser ADC range
            col_shifted[c] = col_sum[c] >>> cfg_range_shift_i;

            // Saturate to the code range
            if (col_shifted[c] > 2 ** (ADC_BITS - 1) - 1) begin
                code_d[c] = ADC_BITS'(2 ** (ADC_BITS - 1) - 1);
            end else if (col_shifted[c] < -(2 ** (ADC_BITS - 1))) begin
                code_d[c] = ADC_BITS'(-(2 ** (ADC_BITS - 1)));
            end else begin
                code_d[c] = col_shifted[c][ADC_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                code_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < NUM_COLS; c++) begin
                code_q[c] <= code_d[c];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            adc_code_o[c] = code_q[c];
        end
    end

    // Rows driven by a nonzero trit in this plane
    assign active_rows = ($bits(active_rows))'($countones(trit_p_i | trit_n_i));

    // Registered code stays in range and within reach of last plane's rows
    generate
        for (genvar c = 0; c < NUM_COLS; c++) begin : g_code_chk
            adc_code_bound_a: assert property (
                @(posedge clk) disable iff (!nrst)
                ##1 ((code_q[c] >= 0 ? int'(code_q[c]) : -int'(code_q[c]))
                     <= int'($past(active_rows)))
            );
        end
    endgenerate

endmodule

/* hdl/shift_accumulator.sv */
module shift_accumulator
    import bsmac_pkg::*;
(
    input  logic                               clk,
    input  logic                               nrst,
    input  logic [MAG_BITS_W-1:0]              cfg_mag_bits_i,
    input  logic [SHIFT_W-1:0]                 cfg_range_shift_i,
    input  logic [NUM_COLS-1:0][ADC_BITS-1:0]  adc_code_i,
    input  logic                               first_bit_i,
    output logic [NUM_COLS-1:0][OUT_BITS-1:0]  res_o
);

    logic signed [ACC_BITS-1:0] acc_q [NUM_COLS];
    logic signed [ACC_BITS-1:0] term  [NUM_COLS];
    logic [MAG_BITS_W-1:0]      top_shift;

    // Each code enters at weight 2^(N-1) and moves down one bit per plane
    assign top_shift = cfg_mag_bits_i - MAG_BITS_W'(1);

    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            term[c] = ACC_BITS'(signed'(adc_code_i[c])) <<< top_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                acc_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (first_bit_i) begin
                    // LSB plane starts a fresh sum
                    acc_q[c] <= term[c];
                end else begin
                    acc_q[c] <= (acc_q[c] >>> 1) + term[c];
                end
            end
        end
    end

    // Undo the ADC range shift on the way out
    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            res_o[c] = OUT_BITS'(acc_q[c]) <<< cfg_range_shift_i;
        end
    end

endmodule

/* hdl/seq_ctrl.sv */
module seq_ctrl
    import bsmac_pkg::*;
(
    input  logic                   clk,
    input  logic                   nrst,
    input  logic [MAG_BITS_W-1:0]  cfg_mag_bits_i,
    input  logic                   act_valid_i,
    output logic                   ready_o,
    output logic                   load_o,
    output logic                   first_bit_o,
    output logic                   res_valid_o
);

    // Stage j holds a token during the cycle after edge E+j
    logic [TRACK_DEPTH-1:0]  tracker_q;
    logic [TRACK_DEPTH-1:0]  busy_mask;
    logic [TRACK_DEPTH-1:0]  flight_mask;
    logic [MAG_BITS_W:0]     res_stage;
    logic                    accept;

    // Serializer is busy until its last plane is on the wires
    assign busy_mask   = (TRACK_DEPTH'(1) << (cfg_mag_bits_i - MAG_BITS_W'(1)))
                         - TRACK_DEPTH'(1);
    // Stages 0..N, up to the last accumulate
    assign flight_mask = (TRACK_DEPTH'(1) << ({1'b0, cfg_mag_bits_i} + 1'b1))
                         - TRACK_DEPTH'(1);
    assign res_stage   = {1'b0, cfg_mag_bits_i} + 1'b1;

    assign ready_o     = (tracker_q & busy_mask) == '0;
    assign accept      = act_valid_i && ready_o;
    assign load_o      = accept;
    assign first_bit_o = tracker_q[1];
    assign res_valid_o = tracker_q[res_stage];

    always_ff @(posedge clk) begin
        if (!nrst) begin
            tracker_q <= '0;
        end else begin
            tracker_q <= {tracker_q[TRACK_DEPTH-2:0], accept};
        end
    end

    mag_bits_nonzero_a: assert property (
        @(posedge clk) disable iff (!nrst)
        accept |-> (cfg_mag_bits_i != '0)
    );

    // Acceptances N apart leave room for only two vectors up to the last add
    max_two_in_flight_a: assert property (
        @(posedge clk) disable iff (!nrst)
        $countones(tracker_q & flight_mask) <= 2
    );

endmodule

/* hdl/bsmac_top.sv */
module bsmac_top
    import bsmac_pkg::*;
(
    input  logic                               clk,
    input  logic                               nrst,

    // Held stable while vectors are in flight
    input  logic [MAG_BITS_W-1:0]              cfg_mag_bits_i,
    input  logic [SHIFT_W-1:0]                 cfg_range_shift_i,

    input  logic [NUM_ROWS-1:0][ACT_BITS-1:0]  act_i,
    input  logic                               act_valid_i,
    output logic                               ready_o,

    input  logic                               wgt_we_i,
    input  logic [ROW_ADDR_W-1:0]              wgt_addr_i,
    input  logic [NUM_COLS-1:0]                wgt_data_i,

    // No back-pressure on results
    output logic                               res_valid_o,
    output logic [NUM_COLS-1:0][OUT_BITS-1:0]  res_o
);

    logic                               load;
    logic                               first_bit;
    logic [NUM_ROWS-1:0]                trit_p;
    logic [NUM_ROWS-1:0]                trit_n;
    logic [NUM_ROWS-1:0][NUM_COLS-1:0]  weights;
    logic [NUM_COLS-1:0][ADC_BITS-1:0]  adc_code;

    seq_ctrl seq_ctrl_i (
        .clk            (clk),
        .nrst           (nrst),
        .cfg_mag_bits_i (cfg_mag_bits_i),
        .act_valid_i    (act_valid_i),
        .ready_o        (ready_o),
        .load_o         (load),
        .first_bit_o    (first_bit),
        .res_valid_o    (res_valid_o)
    );

    act_serializer act_serializer_i (
        .clk            (clk),
        .nrst           (nrst),
        .cfg_mag_bits_i (cfg_mag_bits_i),
        .act_i          (act_i),
        .load_i         (load),
        .trit_p_o       (trit_p),
        .trit_n_o       (trit_n)
    );

    weight_store weight_store_i (
        .clk        (clk),
        .nrst       (nrst),
        .wgt_we_i   (wgt_we_i),
        .wgt_addr_i (wgt_addr_i),
        .wgt_data_i (wgt_data_i),
        .weights_o  (weights)
    );

    // Digital stand-in for the analog array and its ADCs
    column_adc column_adc_i (
        .clk               (clk),
        .nrst              (nrst),
        .cfg_range_shift_i (cfg_range_shift_i),
        .trit_p_i          (trit_p),
        .trit_n_i          (trit_n),
        .weights_i         (weights),
        .adc_code_o        (adc_code)
    );

    shift_accumulator shift_accumulator_i (
        .clk               (clk),
        .nrst              (nrst),
        .cfg_mag_bits_i    (cfg_mag_bits_i),
        .cfg_range_shift_i (cfg_range_shift_i),
        .adc_code_i        (adc_code),
        .first_bit_i       (first_bit),
        .res_o             (res_o)
    );

endmodule

/* include/bsmac_tb_model.svh */
`ifndef BSMAC_TB_MODEL_SVH
`define BSMAC_TB_MODEL_SVH

// Magnitude that an N-bit serializer can carry for one activation
function automatic int sat_magnitude(input logic [ACT_BITS-1:0] act, input int n);
    int value;
    int limit;
    value = int'($signed(act));
    limit = (1 << n) - 1;
    if (value < 0) begin
        value = -value;
    end
    if (value > limit) begin
        value = limit;
    end
    return value;
endfunction

// Range shift, then clamp to the signed ADC code
function automatic int adc_convert(input int col_sum, input int shift);
    int code;
    code = col_sum >>> shift;
    if (code > (1 << (ADC_BITS - 1)) - 1) begin
        code = (1 << (ADC_BITS - 1)) - 1;
    end else if (code < -(1 << (ADC_BITS - 1))) begin
        code = -(1 << (ADC_BITS - 1));
    end
    return code;
endfunction

function automatic logic [NUM_COLS-1:0][OUT_BITS-1:0] predict_results(
    input logic [NUM_ROWS-1:0][ACT_BITS-1:0] acts,
    input logic [NUM_ROWS-1:0][NUM_COLS-1:0] wgts,
    input int                                n,
    input int                                shift
);
    logic [NUM_COLS-1:0][OUT_BITS-1:0] res;
    int mag [NUM_ROWS];
    int col_sum;
    int acc;
    for (int r = 0; r < NUM_ROWS; r++) begin
        mag[r] = sat_magnitude(acts[r], n);
    end
    for (int c = 0; c < NUM_COLS; c++) begin
        acc = 0;
        for (int k = 0; k < n; k++) begin
            col_sum = 0;
            for (int r = 0; r < NUM_ROWS; r++) begin
                // Sign of the activation sets the trit polarity
                if (wgts[r][c] && ((mag[r] >> k) & 1) == 1) begin
                    col_sum += acts[r][ACT_BITS-1] ? -1 : 1;
                end
            end
            acc += adc_convert(col_sum, shift) * (1 << k);
        end
        res[c] = OUT_BITS'(acc * (1 << shift));
    end
    return res;
endfunction

`endif

/* dv/bsmac_tb.sv */
module bsmac_tb
    import bsmac_pkg::*;
();

    localparam int ACCEPT_LIMIT = 40;
    localparam int DRAIN_LIMIT  = 60;
    localparam logic [ACT_BITS-1:0] MOST_NEG = ACT_BITS'(1) << (ACT_BITS - 1);
    localparam logic [ACT_BITS-1:0] MOST_POS = ~MOST_NEG;

    logic                               clk;
    logic                               nrst;
    logic [MAG_BITS_W-1:0]              cfg_mag_bits_i;
    logic [SHIFT_W-1:0]                 cfg_range_shift_i;
    logic [NUM_ROWS-1:0][ACT_BITS-1:0]  act_i;
    logic                               act_valid_i;
    logic                               ready_o;
    logic                               wgt_we_i;
    logic [ROW_ADDR_W-1:0]              wgt_addr_i;
    logic [NUM_COLS-1:0]                wgt_data_i;
    logic                               res_valid_o;
    logic [NUM_COLS-1:0][OUT_BITS-1:0]  res_o;

    integer                             seed;
    int                                 cyc;
    int                                 last_accept;
    bit                                 check_interval;
    logic [NUM_ROWS-1:0][NUM_COLS-1:0]  wgt_model;
    logic [NUM_COLS-1:0][OUT_BITS-1:0]  exp_q [$];
    int                                 accept_cyc_q [$];

    `include "bsmac_tb_model.svh"

    bsmac_top dut_i (
        .clk               (clk),
        .nrst              (nrst),
        .cfg_mag_bits_i    (cfg_mag_bits_i),
        .cfg_range_shift_i (cfg_range_shift_i),
        .act_i             (act_i),
        .act_valid_i       (act_valid_i),
        .ready_o           (ready_o),
        .wgt_we_i          (wgt_we_i),
        .wgt_addr_i        (wgt_addr_i),
        .wgt_data_i        (wgt_data_i),
        .res_valid_o       (res_valid_o),
        .res_o             (res_o)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    // Predictions are taken at acceptance and compared in order
    always @(posedge clk) begin
        logic [NUM_COLS-1:0][OUT_BITS-1:0] exp;
        int lat;
        if (nrst && res_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("res_valid_o pulsed with no vector in flight");
                abort_run();
            end else begin
                exp = exp_q.pop_front();
                lat = cyc - accept_cyc_q.pop_front();
                // Pulse follows edge E+N+1, so it is seen at edge E+N+2
                assert (lat == int'(cfg_mag_bits_i) + 2) else begin
                    $display("** Error res_valid_o latency: expected 0x%h got 0x%h",
                             int'(cfg_mag_bits_i) + 2, lat);
                    abort_run();
                end
                for (int c = 0; c < NUM_COLS; c++) begin
                    assert (res_o[c] == exp[c]) else begin
                        $display("** Error res_o[%0d]: expected 0x%h got 0x%h",
                                 c, exp[c], res_o[c]);
                        abort_run();
                    end
                end
            end
        end
        if (nrst && act_valid_i && ready_o) begin
            if (check_interval && last_accept >= 0) begin
                assert (cyc - last_accept == int'(cfg_mag_bits_i)) else begin
                    $display("** Error ready_o acceptance interval: expected 0x%h got 0x%h",
                             int'(cfg_mag_bits_i), cyc - last_accept);
                    abort_run();
                end
            end
            last_accept = cyc;
            exp_q.push_back(predict_results(act_i, wgt_model, int'(cfg_mag_bits_i),
                                            int'(cfg_range_shift_i)));
            accept_cyc_q.push_back(cyc);
        end
        cyc++;
    end

    function automatic logic [NUM_ROWS-1:0][ACT_BITS-1:0] random_vector();
        logic [NUM_ROWS-1:0][ACT_BITS-1:0] vec;
        logic [31:0] rnd;
        for (int r = 0; r < NUM_ROWS; r++) begin
            rnd = $random(seed);
            // Extremes often enough to hit saturation
            case (rnd[10:8])
                3'd0:    vec[r] = MOST_NEG;
                3'd1:    vec[r] = MOST_POS;
                default: vec[r] = rnd[ACT_BITS-1:0];
            endcase
        end
        return vec;
    endfunction

    task automatic load_weights(input bit all_ones);
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(negedge clk);
            wgt_we_i     = 1'b1;
            wgt_addr_i   = ROW_ADDR_W'(r);
            wgt_data_i   = all_ones ? '1 : NUM_COLS'($random(seed));
            wgt_model[r] = wgt_data_i;
        end
        @(negedge clk);
        wgt_we_i = 1'b0;
    endtask

    task automatic set_config(input int n, input int shift);
        @(negedge clk);
        cfg_mag_bits_i    = MAG_BITS_W'(n);
        cfg_range_shift_i = SHIFT_W'(shift);
    endtask

    // Valid stays high until the DUT takes the vector
    task automatic send_vector(input logic [NUM_ROWS-1:0][ACT_BITS-1:0] vec);
        int waited;
        bit taken;
        @(negedge clk);
        act_i       = vec;
        act_valid_i = 1'b1;
        waited      = 0;
        taken       = 1'b0;
        while (!taken) begin
            if (waited == ACCEPT_LIMIT) begin
                $display("vector not accepted within timeout");
                abort_run();
            end else begin
                @(posedge clk);
                taken = ready_o;
                waited++;
            end
        end
    endtask

    task automatic idle_gap(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            act_valid_i = 1'b0;
            act_i       = random_vector();
        end
    endtask

    task automatic drain_results();
        int waited;
        @(negedge clk);
        act_valid_i = 1'b0;
        waited      = 0;
        while (exp_q.size() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                $display("no result valid within timeout");
                abort_run();
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        // Empty tracker before the config may change
        repeat (TRACK_DEPTH + 1) @(negedge clk);
    endtask

    initial begin
        seed              = 20063;
        clk               = 1'b0;
        nrst              = 1'b0;
        cfg_mag_bits_i    = MAG_BITS_W'(4);
        cfg_range_shift_i = '0;
        act_i             = '0;
        act_valid_i       = 1'b0;
        wgt_we_i          = 1'b0;
        wgt_addr_i        = '0;
        wgt_data_i        = '0;
        wgt_model         = '0;
        cyc               = 0;
        last_accept       = -1;
        check_interval    = 1'b0;
        repeat (2) @(negedge clk);
        nrst = 1'b1;

        @(negedge clk);
        assert (ready_o == 1'b1) else begin
            $display("** Error ready_o: expected 0x1 got 0x%h", ready_o);
            abort_run();
        end
        assert (res_valid_o == 1'b0) else begin
            $display("** Error res_valid_o: expected 0x0 got 0x%h", res_valid_o);
            abort_run();
        end

        // Zero vector over random weights
        load_weights(1'b0);
        send_vector('0);
        drain_results();

        for (int n = 1; n <= 7; n++) begin
            set_config(n, 0);
            load_weights(1'b0);
            repeat (6) send_vector(random_vector());
            drain_results();
        end

        // Full columns push the sums past the code range
        load_weights(1'b1);
        for (int s = 0; s < 4; s++) begin
            set_config(7, s);
            send_vector({NUM_ROWS{MOST_POS}});
            send_vector({NUM_ROWS{MOST_NEG}});
            send_vector(random_vector());
            drain_results();
        end

        // Valid held high, overlapped vectors
        check_interval = 1'b1;
        for (int n = 1; n <= 7; n++) begin
            set_config(n, n % 4);
            load_weights(1'b0);
            last_accept = -1;
            repeat (5) send_vector(random_vector());
            drain_results();
        end
        check_interval = 1'b0;

        for (int b = 0; b < 4; b++) begin
            set_config(1 + ($unsigned($random(seed)) % 7), $unsigned($random(seed)) % 4);
            load_weights(1'b0);
            for (int v = 0; v < 50; v++) begin
                send_vector(random_vector());
                idle_gap($unsigned($random(seed)) % 4);
            end
            drain_results();
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* bsmac_top.f */
+incdir+include
hdl/bsmac_pkg.sv
hdl/act_serializer.sv
hdl/weight_store.sv
hdl/column_adc.sv
hdl/shift_accumulator.sv
hdl/seq_ctrl.sv
hdl/bsmac_top.sv
dv/bsmac_tb.sv

/* Bender.yml */
package:
  name: bsmac

sources:
  - files:
      - hdl/bsmac_pkg.sv
      - hdl/act_serializer.sv
      - hdl/weight_store.sv
      - hdl/column_adc.sv
      - hdl/shift_accumulator.sv
      - hdl/seq_ctrl.sv
      - hdl/bsmac_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/bsmac_tb.sv
